/* compile.f */
+incdir+tests
source/cvt_fmt_pkg.sv
source/cvt_ctrl_pkg.sv
source/lead_zero_count.sv
source/int_normalizer.sv
source/cvt_pipe_regs.sv
source/fp_round.sv
source/i2f_pack.sv
source/i2f_cast_top.sv
tests/tb_i2f_cast.sv

/* run_sim.sh */
#!/bin/sh
# Build the int to float testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal --top-module tb_i2f_cast -f compile.f \
  -o sim_i2f_cast > build.log 2>&1 \
  && ./obj_dir/sim_i2f_cast > sim.log 2>&1 \
  || echo "Build or simulation returned an error status"

cat build.log sim.log 2>/dev/null

grep -qx "All tests passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

/* tests/i2f_ref_model.svh */
// Int to float reference model
`ifndef I2F_REF_MODEL_SVH
`define I2F_REF_MODEL_SVH

// Behavioral conversion straight from the IEEE rules
// Status is returned through the output argument
function automatic cvt_fmt_pkg::fp_word_t ref_int_to_float(
  input  cvt_fmt_pkg::int_word_t   op,
  input  logic                     is_unsigned,
  input  cvt_ctrl_pkg::roundmode_e mode,
  output cvt_ctrl_pkg::status_t    status
);
  logic        neg;    // Value below zero
  logic [31:0] mag;    // Absolute value where INT_MIN gives 2^31
  logic [31:0] sig;    // 24-bit significand with hidden bit at 23
  logic [31:0] body;   // {exponent, fraction}
  logic        rnd;
  logic        stk;
  logic        up;
  int          msb;    // Position of the leading one

  neg    = op[31] & ~is_unsigned;
  mag    = neg ? (~op + 32'd1) : op;
  status = '0;
  if (mag == 32'd0) begin
    return '0;                                   // Always +0
  end
  msb = 31;
  while (!mag[msb]) msb--;
  if (msb <= 23) begin
    sig = mag << (23 - msb);                     // Fits with nothing dropped
    rnd = 1'b0;
    stk = 1'b0;
  end else begin
    sig = mag >> (msb - 23);
    rnd = mag[msb-24];                           // First dropped bit
    stk = |(mag & ((32'd1 << (msb - 24)) - 32'd1));
  end
  // Round-up rule per mode
  if (mode == cvt_ctrl_pkg::RNE)      up = rnd & (stk | sig[0]);
  else if (mode == cvt_ctrl_pkg::RDN) up = (rnd | stk) & neg;
  else if (mode == cvt_ctrl_pkg::RUP) up = (rnd | stk) & ~neg;
  else if (mode == cvt_ctrl_pkg::RMM) up = rnd;
  else                                up = 1'b0;  // RTZ truncates
  body = ((32'd127 + msb) << 23) + (sig & 32'h007F_FFFF);
  body = body + {31'd0, up};                     // Fraction overflow bumps the exponent
  status.NX = rnd | stk;
  return {neg, body[30:0]};
endfunction

`endif

/* tests/tb_i2f_cast.sv */
// Int to float converter testbench
`timescale 1ns/100ps
`default_nettype none

module tb_i2f_cast;

  localparam int ClkPeriod = 40;
  localparam int NumRandom = 64;                 // Random part of the table
  localparam logic [31:0] Seed = 32'h5802_4e07;
  localparam cvt_ctrl_pkg::status_t StExact   = 5'b00000;
  localparam cvt_ctrl_pkg::status_t StInexact = 5'b00001;  // NX only

  logic clk, rst_n, flush, is_unsigned, in_valid, in_ready, out_valid, out_ready, busy;
  cvt_fmt_pkg::int_word_t   operand;
  cvt_ctrl_pkg::roundmode_e rnd_mode;
  cvt_fmt_pkg::fp_word_t    result;
  cvt_ctrl_pkg::status_t    status;

  // --------------------
  // Stimulus table
  // --------------------
  cvt_fmt_pkg::int_word_t   tbl_operand[$];
  logic                     tbl_unsigned[$];
  cvt_ctrl_pkg::roundmode_e tbl_mode[$];
  cvt_fmt_pkg::fp_word_t    tbl_result[$];
  cvt_ctrl_pkg::status_t    tbl_status[$];
  int                       expq[$];             // Table indices in flight with oldest first

  `include "i2f_ref_model.svh"

  i2f_cast_top i_i2f_cast_top (
    .clk_i ( clk ), .rst_n_i ( rst_n ), .flush_i ( flush ),
    .operand_i ( operand ), .is_unsigned_i ( is_unsigned ), .rnd_mode_i ( rnd_mode ),
    .in_valid_i ( in_valid ), .in_ready_o ( in_ready ),
    .result_o ( result ), .status_o ( status ),
    .out_valid_o ( out_valid ), .out_ready_i ( out_ready ), .busy_o ( busy )
  );

  always #(ClkPeriod / 2) clk = ~clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_result(input cvt_fmt_pkg::fp_word_t act, input cvt_fmt_pkg::fp_word_t exp,
                              input int idx);
    if (act !== exp) report_failure($sformatf("Mismatch at %0t: entry %0d result %h, expected %h",
                                              $time, idx, act, exp));
  endtask

  task automatic check_status(input cvt_ctrl_pkg::status_t act, input cvt_ctrl_pkg::status_t exp,
                              input int idx);
    if (act !== exp) report_failure($sformatf("Mismatch at %0t: entry %0d status %b, expected %b",
                                              $time, idx, act, exp));
  endtask

  task automatic check_flag(input logic act, input logic exp, input string what);
    if (act !== exp) report_failure($sformatf("Mismatch at %0t: %s is %b, expected %b",
                                              $time, what, act, exp));
  endtask

  task automatic add_entry(input cvt_fmt_pkg::int_word_t op, input logic uns,
                           input cvt_ctrl_pkg::roundmode_e mode,
                           input cvt_fmt_pkg::fp_word_t res, input cvt_ctrl_pkg::status_t st);
    tbl_operand.push_back(op);
    tbl_unsigned.push_back(uns);
    tbl_mode.push_back(mode);
    tbl_result.push_back(res);
    tbl_status.push_back(st);
  endtask

  task automatic build_table();
    cvt_fmt_pkg::fp_word_t    ref_res;
    cvt_ctrl_pkg::status_t    ref_st;
    cvt_fmt_pkg::int_word_t   op;
    cvt_ctrl_pkg::roundmode_e mode;
    logic                     uns;
    add_entry(32'h0000_0001, 1'b0, cvt_ctrl_pkg::RNE, 32'h3F80_0000, StExact);
    add_entry(32'h0000_0001, 1'b1, cvt_ctrl_pkg::RTZ, 32'h3F80_0000, StExact);
    add_entry(32'hFFFF_FFFF, 1'b0, cvt_ctrl_pkg::RDN, 32'hBF80_0000, StExact);  // -1
    add_entry(32'hFFFF_FFFF, 1'b0, cvt_ctrl_pkg::RMM, 32'hBF80_0000, StExact);
    add_entry(32'h0100_0000, 1'b1, cvt_ctrl_pkg::RUP, 32'h4B80_0000, StExact);  // 2^24
    add_entry(32'h0100_0000, 1'b0, cvt_ctrl_pkg::RNE, 32'h4B80_0000, StExact);
    add_entry(32'h0000_0064, 1'b0, cvt_ctrl_pkg::RUP, 32'h42C8_0000, StExact);  // 100
    add_entry(32'hFFFF_FF9C, 1'b0, cvt_ctrl_pkg::RTZ, 32'hC2C8_0000, StExact);  // -100
    add_entry(32'h00FF_FFFF, 1'b0, cvt_ctrl_pkg::RMM, 32'h4B7F_FFFF, StExact);  // 24 bits exact
    add_entry(32'h0000_0000, 1'b0, cvt_ctrl_pkg::RDN, 32'h0000_0000, StExact);  // Zero is +0
    add_entry(32'h8000_0000, 1'b0, cvt_ctrl_pkg::RNE, 32'hCF00_0000, StExact);  // INT_MIN
    add_entry(32'h8000_0000, 1'b1, cvt_ctrl_pkg::RNE, 32'h4F00_0000, StExact);  // 2^31
    add_entry(32'hFFFF_FFFF, 1'b1, cvt_ctrl_pkg::RTZ, 32'h4F7F_FFFF, StInexact);
    add_entry(32'hFFFF_FFFF, 1'b1, cvt_ctrl_pkg::RUP, 32'h4F80_0000, StInexact); // Carry to 2^32
    add_entry(32'hFFFF_FFFF, 1'b1, cvt_ctrl_pkg::RNE, 32'h4F80_0000, StInexact);
    add_entry(32'hFFFF_FFFF, 1'b1, cvt_ctrl_pkg::RDN, 32'h4F7F_FFFF, StInexact);
    add_entry(32'h0100_0001, 1'b1, cvt_ctrl_pkg::RNE, 32'h4B80_0000, StInexact); // Tie kept even
    add_entry(32'h0100_0001, 1'b1, cvt_ctrl_pkg::RMM, 32'h4B80_0001, StInexact); // Tie goes away
    add_entry(32'h0100_0003, 1'b0, cvt_ctrl_pkg::RNE, 32'h4B80_0002, StInexact); // Tie on odd lsb
    add_entry(32'hFEFF_FFFF, 1'b0, cvt_ctrl_pkg::RDN, 32'hCB80_0001, StInexact); // -(2^24+1)
    add_entry(32'hFEFF_FFFF, 1'b0, cvt_ctrl_pkg::RUP, 32'hCB80_0000, StInexact);
    add_entry(32'h7FFF_FFFF, 1'b0, cvt_ctrl_pkg::RDN, 32'h4EFF_FFFF, StInexact);
    add_entry(32'h7FFF_FFFF, 1'b0, cvt_ctrl_pkg::RMM, 32'h4F00_0000, StInexact);
    add_entry(32'h0100_0001, 1'b1, cvt_ctrl_pkg::RTZ, 32'h4B80_0000, StInexact);
    // Hand values must agree with the model
    for (int i = 0; i < tbl_operand.size(); i++) begin
      ref_res = ref_int_to_float(tbl_operand[i], tbl_unsigned[i], tbl_mode[i], ref_st);
      if (ref_res !== tbl_result[i] || ref_st !== tbl_status[i])
        report_failure($sformatf("Reference model disagrees with table entry %0d", i));
    end
    for (int i = 0; i < NumRandom; i++) begin
      op      = $urandom;
      op      = op >> ($urandom % 32);           // Spread of magnitudes
      uns     = $urandom % 2;
      mode    = cvt_ctrl_pkg::roundmode_e'($urandom % 5);
      ref_res = ref_int_to_float(op, uns, mode, ref_st);
      add_entry(op, uns, mode, ref_res, ref_st);
    end
  endtask

  // Called just after a rising edge and returns 2 ns after the accepting edge
  task automatic send_entry(input int idx);
    operand     = tbl_operand[idx];
    is_unsigned = tbl_unsigned[idx];
    rnd_mode    = tbl_mode[idx];
    in_valid    = 1'b1;
    @(negedge clk);
    while (!in_ready) @(negedge clk);            // Held until the DUT can take it
    expq.push_back(idx);                         // Transfer on the coming edge
    @(posedge clk);
    #2;
    in_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (expq.size() != 0) @(posedge clk);
    #2;
  endtask

  // --------------------
  // Receive and check
  // --------------------
  initial begin : receive
    int idx;
    forever begin
      @(negedge clk);                            // Outputs settled mid-cycle
      if (rst_n && out_valid && out_ready) begin
        if (expq.size() == 0) report_failure("A result came out with no item in flight");
        idx = expq.pop_front();
        check_result(result, tbl_result[idx], idx);
        check_status(status, tbl_status[idx], idx);
      end
    end
  end

  initial begin : watchdog
    #1;                                          // Table is built at time 0
    #((tbl_operand.size() * 8 + 100) * ClkPeriod);
    report_failure("Timeout, the converter did not finish all items in time");
  end

  initial begin : main
    clk         = 1'b0;
    rst_n       = 1'b0;
    flush       = 1'b0;
    operand     = '0;
    is_unsigned = 1'b0;
    rnd_mode    = cvt_ctrl_pkg::RNE;
    in_valid    = 1'b0;
    out_ready   = 1'b0;
    void'($urandom(Seed));
    build_table();
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    out_ready = 1'b1;
    @(negedge clk);
    check_flag(out_valid, 1'b0, "out_valid after reset");
    check_flag(busy, 1'b0, "busy after reset");
    check_flag(in_ready, 1'b1, "in_ready after reset");
    @(posedge clk);
    #2;
    // --------------------
    // Full table, streaming
    // --------------------
    for (int i = 0; i < tbl_operand.size(); i++) send_entry(i);
    wait_drained();
    // --------------------
    // Back-pressure
    // --------------------
    // Entries 6 to 13 all have distinct results so loss or duplication shows up
    out_ready = 1'b0;
    fork
      for (int i = 6; i < 14; i++) send_entry(i);
      begin
        repeat (8) @(negedge clk);
        check_flag(in_ready, 1'b0, "in_ready while stalled");
        check_flag(busy, 1'b1, "busy while stalled");
        check_flag(out_valid, 1'b1, "out_valid while stalled");
        @(posedge clk);
        #2 out_ready = 1'b1;                     // Release the stall
      end
    join
    wait_drained();
    // --------------------
    // Flush with items in flight
    // --------------------
    out_ready = 1'b0;
    send_entry(10);
    send_entry(11);
    flush = 1'b1;
    @(posedge clk);
    #2 flush = 1'b0;
    @(negedge clk);
    check_flag(out_valid, 1'b0, "out_valid after flush");
    check_flag(busy, 1'b0, "busy after flush");
    expq.delete();                               // Flushed items never come out
    @(posedge clk);
    #2 out_ready = 1'b1;
    send_entry(12);
    send_entry(13);
    wait_drained();
    repeat (4) @(posedge clk);                   // No stray results afterwards
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* source/i2f_cast_top.sv */
// Int to float converter
`timescale 1ns/100ps
`default_nettype none

module i2f_cast_top #(
  parameter int unsigned NumInpRegs = 1,  // Stages before normalization
  parameter int unsigned NumMidRegs = 1,  // Stages between normalize and round
  parameter int unsigned NumOutRegs = 1   // Stages after rounding
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     flush_i,
  // Operand side
  input  cvt_fmt_pkg::int_word_t   operand_i,
  input  logic                     is_unsigned_i,
  input  cvt_ctrl_pkg::roundmode_e rnd_mode_i,
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  // Result side
  output cvt_fmt_pkg::fp_word_t    result_o,
  output cvt_ctrl_pkg::status_t    status_o,
  output logic                     out_valid_o,
  input  logic                     out_ready_i,
  output logic                     busy_o       // Items in flight
);

  localparam int unsigned RmWidth  = $bits(cvt_ctrl_pkg::roundmode_e);
  localparam int unsigned StWidth  = $bits(cvt_ctrl_pkg::status_t);
  localparam int unsigned InpWidth = cvt_fmt_pkg::INT_WIDTH + 1 + RmWidth;
  localparam int unsigned MidWidth = 1 + cvt_fmt_pkg::EXP_WIDTH + cvt_fmt_pkg::INT_WIDTH
                                   + 1 + RmWidth;
  localparam int unsigned OutWidth = cvt_fmt_pkg::FP_WIDTH + StWidth;

  // --------------------
  // Input section
  // --------------------
  logic [InpWidth-1:0]      inp_data_q;
  logic                     inp_valid, inp_busy;
  cvt_fmt_pkg::int_word_t   inp_operand;
  logic                     inp_unsigned;
  cvt_ctrl_pkg::roundmode_e inp_rnd_mode;

  // Mid section fed by the normalizer
  logic [cvt_fmt_pkg::EXP_WIDTH-1:0] norm_exp, mid_exp;
  cvt_fmt_pkg::int_word_t            norm_mant, mid_mant;
  logic                              norm_sign, norm_zero, mid_sign, mid_zero;
  logic [MidWidth-1:0]               mid_data_q;
  logic                              mid_ready, mid_valid, mid_busy;
  cvt_ctrl_pkg::roundmode_e          mid_rnd_mode;

  // Output section
  cvt_fmt_pkg::fp_word_t    pack_result;
  cvt_ctrl_pkg::status_t    pack_status;
  logic [OutWidth-1:0]      out_data_q;
  logic                     out_ready, out_busy;

  cvt_pipe_regs #(.NumRegs(NumInpRegs), .DataWidth(InpWidth)) i_inp_regs (
    .clk_i, .rst_n_i, .flush_i,
    .valid_i ( in_valid_i ), .ready_o ( in_ready_o ),
    .data_i  ( {operand_i, is_unsigned_i, rnd_mode_i} ),
    .valid_o ( inp_valid  ), .ready_i ( mid_ready  ),
    .data_o  ( inp_data_q ), .busy_o  ( inp_busy   )
  );

  assign inp_operand  = inp_data_q[InpWidth-1 -: cvt_fmt_pkg::INT_WIDTH];
  assign inp_unsigned = inp_data_q[RmWidth];
  assign inp_rnd_mode = cvt_ctrl_pkg::roundmode_e'(inp_data_q[RmWidth-1:0]);

  int_normalizer i_int_normalizer (
    .operand_i ( inp_operand ), .is_unsigned_i ( inp_unsigned ),
    .sign_o    ( norm_sign   ), .exp_o         ( norm_exp     ),
    .mant_o    ( norm_mant   ), .is_zero_o     ( norm_zero    )
  );

  // --------------------
  // Mid section
  // --------------------
  cvt_pipe_regs #(.NumRegs(NumMidRegs), .DataWidth(MidWidth)) i_mid_regs (
    .clk_i, .rst_n_i, .flush_i,
    .valid_i ( inp_valid  ), .ready_o ( mid_ready ),
    .data_i  ( {norm_sign, norm_exp, norm_mant, norm_zero, inp_rnd_mode} ),
    .valid_o ( mid_valid  ), .ready_i ( out_ready ),
    .data_o  ( mid_data_q ), .busy_o  ( mid_busy  )
  );

  assign mid_sign     = mid_data_q[MidWidth-1];
  assign mid_exp      = mid_data_q[MidWidth-2 -: cvt_fmt_pkg::EXP_WIDTH];
  assign mid_mant     = mid_data_q[RmWidth+1 +: cvt_fmt_pkg::INT_WIDTH];
  assign mid_zero     = mid_data_q[RmWidth];
  assign mid_rnd_mode = cvt_ctrl_pkg::roundmode_e'(mid_data_q[RmWidth-1:0]);

  i2f_pack i_i2f_pack (
    .sign_i     ( mid_sign     ), .exp_i      ( mid_exp      ),
    .mant_i     ( mid_mant     ), .is_zero_i  ( mid_zero     ),
    .rnd_mode_i ( mid_rnd_mode ), .result_o   ( pack_result  ),
    .status_o   ( pack_status  )
  );

  // --------------------
  // Output section
  // --------------------
  cvt_pipe_regs #(.NumRegs(NumOutRegs), .DataWidth(OutWidth)) i_out_regs (
    .clk_i, .rst_n_i, .flush_i,
    .valid_i ( mid_valid   ), .ready_o ( out_ready   ),
    .data_i  ( {pack_result, pack_status} ),
    .valid_o ( out_valid_o ), .ready_i ( out_ready_i ),
    .data_o  ( out_data_q  ), .busy_o  ( out_busy    )
  );

  assign result_o = out_data_q[OutWidth-1 -: cvt_fmt_pkg::FP_WIDTH];
  assign status_o = out_data_q[StWidth-1:0];

  assign busy_o = inp_busy | mid_busy | out_busy;  // Any stage occupied

endmodule

`default_nettype wire

/* source/i2f_pack.sv */
// Float result assembly
`timescale 1ns/100ps
`default_nettype none

module i2f_pack (
  input  logic                              sign_i,      // Sign of the operand
  input  logic [cvt_fmt_pkg::EXP_WIDTH-1:0] exp_i,       // Biased exponent
  input  cvt_fmt_pkg::int_word_t            mant_i,      // Normalized with leading one at MSB
  input  logic                              is_zero_i,   // Operand was zero
  input  cvt_ctrl_pkg::roundmode_e          rnd_mode_i,
  output cvt_fmt_pkg::fp_word_t             result_o,
  output cvt_ctrl_pkg::status_t             status_o
);

  // Bit just below the fraction
  localparam int unsigned RndBit = cvt_fmt_pkg::INT_WIDTH - cvt_fmt_pkg::FP_MAN_BITS - 2;

  logic [cvt_fmt_pkg::FP_MAN_BITS-1:0] frac;          // Fraction before rounding
  logic [1:0]                          round_sticky;  // {round, sticky}
  logic [cvt_fmt_pkg::FP_WIDTH-2:0]    pre_round;     // {exponent, fraction}
  logic [cvt_fmt_pkg::FP_WIDTH-2:0]    rounded;

  // --------------------
  // Round/sticky
  // --------------------
  // Bit 31 is the hidden one and is dropped
  assign frac            = mant_i[cvt_fmt_pkg::INT_WIDTH-2 -: cvt_fmt_pkg::FP_MAN_BITS]; // 30..8
  assign round_sticky[1] = mant_i[RndBit];         // Bit 7
  assign round_sticky[0] = |mant_i[RndBit-1:0];    // Bits 6..0 collapsed

  // Exponent never exceeds 158 so its top bit stays clear
  assign pre_round = {exp_i[cvt_fmt_pkg::FP_EXP_BITS-1:0], frac};

  // --------------------
  // Rounding
  // --------------------
  fp_round i_fp_round (
    .abs_value_i    ( pre_round    ),
    .sign_i         ( sign_i       ),
    .round_sticky_i ( round_sticky ),
    .rnd_mode_i     ( rnd_mode_i   ),
    .abs_rounded_o  ( rounded      )
  );

  // Zero has no leading one so it gives +0 directly
  assign result_o = is_zero_i ? '0 : {sign_i, rounded};

  // 32-bit ints always fit binary32 so only NX can be raised
  assign status_o = '{NV: 1'b0, DZ: 1'b0, OF: 1'b0, UF: 1'b0, NX: |round_sticky};

endmodule

`default_nettype wire

/* source/fp_round.sv */
// Float rounding unit
`timescale 1ns/100ps
`default_nettype none

module fp_round (
  input  logic [cvt_fmt_pkg::FP_WIDTH-2:0] abs_value_i,     // {exponent, fraction}
  input  logic                             sign_i,          // Sign of the value
  input  logic [1:0]                       round_sticky_i,  // {round, sticky}
  input  cvt_ctrl_pkg::roundmode_e         rnd_mode_i,
  output logic [cvt_fmt_pkg::FP_WIDTH-2:0] abs_rounded_o    // Rounded magnitude
);

  logic round_up;   // Add one ulp
  logic inexact;    // Any bits dropped

  assign inexact = |round_sticky_i;

  // --------------------
  // Round-up decision
  // --------------------
  always_comb begin : rnd_decision
    unique case (rnd_mode_i)
      // Above half or exactly half with odd lsb
      cvt_ctrl_pkg::RNE: round_up = round_sticky_i[1] & (round_sticky_i[0] | abs_value_i[0]);
      cvt_ctrl_pkg::RTZ: round_up = 1'b0;               // Plain truncation
      cvt_ctrl_pkg::RDN: round_up = inexact & sign_i;   // Magnitude grows when negative
      cvt_ctrl_pkg::RUP: round_up = inexact & ~sign_i;  // Magnitude grows when positive
      cvt_ctrl_pkg::RMM: round_up = round_sticky_i[1];  // Half and above go away from zero
      default:           round_up = 1'b0;               // Unused encodings truncate
    endcase
  end

  // Fraction carry ripples into the exponent field
  // 0x7FFFFF plus one becomes the next power of two
  assign abs_rounded_o = abs_value_i + {{(cvt_fmt_pkg::FP_WIDTH - 2){1'b0}}, round_up};

endmodule

`default_nettype wire

/* source/cvt_pipe_regs.sv */
// Valid/ready register chain
`timescale 1ns/100ps
`default_nettype none

module cvt_pipe_regs #(
  parameter int unsigned NumRegs   = 1,  // Stage count where 0 is pass-through
  parameter int unsigned DataWidth = 1   // Payload width per stage
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 flush_i,   // Drop everything in flight
  // Upstream side
  input  logic                 valid_i,
  output logic                 ready_o,
  input  logic [DataWidth-1:0] data_i,
  // Downstream side
  output logic                 valid_o,
  input  logic                 ready_i,
  output logic [DataWidth-1:0] data_o,
  output logic                 busy_o     // Some stage holds an item
);

  // Index i is the view after i stages and 0 is the input
  logic [0:NumRegs]                valid;
  logic [0:NumRegs]                ready;  // Combinational and travels backwards
  logic [0:NumRegs][DataWidth-1:0] data;

  assign valid[0] = valid_i;
  assign data[0]  = data_i;
  assign ready_o  = ready[0];

  // --------------------
  // Register stages
  // --------------------
  for (genvar i = 0; i < NumRegs; i++) begin : gen_stage
    logic                 valid_q;
    logic [DataWidth-1:0] data_q;
    logic                 load;

    // Advance when the next stage moves on or only holds a bubble
    assign ready[i] = ready[i+1] | ~valid[i+1];
    assign load     = ready[i] & valid[i];  // Real item arriving

    always_ff @(posedge clk_i or negedge rst_n_i) begin : valid_reg
      if (!rst_n_i) begin
        valid_q <= 1'b0;
      end else if (flush_i) begin
        valid_q <= 1'b0;           // Items in flight are lost
      end else if (ready[i]) begin
        valid_q <= valid[i];
      end
    end

    always_ff @(posedge clk_i) begin : data_reg
      if (load) begin
        data_q <= data[i];         // Payload only moves with a valid item
      end
    end

    assign valid[i+1] = valid_q;
    assign data[i+1]  = data_q;
  end

  // Last stage is driven by the consumer
  assign ready[NumRegs] = ready_i;
  assign valid_o        = valid[NumRegs];
  assign data_o         = data[NumRegs];

  if (NumRegs > 0) begin : gen_busy
    assign busy_o = |valid[1:NumRegs];
  end else begin : gen_no_busy
    assign busy_o = 1'b0;          // Nothing can be held
  end

endmodule

`default_nettype wire

/* source/int_normalizer.sv */
// Integer normalization
`timescale 1ns/100ps
`default_nettype none

module int_normalizer (
  input  cvt_fmt_pkg::int_word_t             operand_i,      // Raw integer
  input  logic                               is_unsigned_i,  // Read operand as unsigned
  output logic                               sign_o,         // Sign of the value
  output logic [cvt_fmt_pkg::EXP_WIDTH-1:0]  exp_o,          // Biased exponent
  output cvt_fmt_pkg::int_word_t             mant_o,         // Leading one at the MSB
  output logic                               is_zero_o       // Operand was zero
);

  // Exponent of a value whose leading one sits at bit 31
  localparam int unsigned ExpTop = cvt_fmt_pkg::FP_BIAS + cvt_fmt_pkg::INT_WIDTH - 1;

  cvt_fmt_pkg::int_word_t                magnitude;  // Absolute value
  logic [cvt_fmt_pkg::LZC_WIDTH-1:0]     lz_cnt;     // Normalization shift
  logic                                  lz_empty;

  // --------------------
  // Sign and magnitude
  // --------------------
  // Unsigned is never negative
  assign sign_o    = operand_i[cvt_fmt_pkg::INT_WIDTH-1] & ~is_unsigned_i;
  assign magnitude = sign_o ? -operand_i : operand_i;  // INT_MIN maps to 2^31 unsigned

  // --------------------
  // Normalization
  // --------------------
  lead_zero_count i_lzc (
    .in_i    ( magnitude ),
    .cnt_o   ( lz_cnt    ),
    .empty_o ( lz_empty  )
  );

  // Shift the leading one up to bit 31
  assign mant_o = magnitude << lz_cnt;

  // Each leading zero lowers the exponent by one
  assign exp_o = ExpTop[cvt_fmt_pkg::EXP_WIDTH-1:0]
               - {{(cvt_fmt_pkg::EXP_WIDTH - cvt_fmt_pkg::LZC_WIDTH){1'b0}}, lz_cnt};

  assign is_zero_o = lz_empty;  // Exponent and mantissa are don't-care then

endmodule

`default_nettype wire

/* source/lead_zero_count.sv */
// Leading-zero counter
`timescale 1ns/100ps
`default_nettype none

module lead_zero_count (
  input  cvt_fmt_pkg::int_word_t             in_i,     // Value to scan
  output logic [cvt_fmt_pkg::LZC_WIDTH-1:0]  cnt_o,    // Zeros above the first one
  output logic                               empty_o   // No bit set at all
);

  logic found;  // A one has been seen during the scan

  // Priority scan from the MSB down
  // Counting stops at the first set bit
  always_comb begin : scan
    cnt_o = '0;
    found = 1'b0;
    for (int i = cvt_fmt_pkg::INT_WIDTH - 1; i >= 0; i--) begin
      if (!found) begin
        if (in_i[i]) begin
          found = 1'b1;             // Leading one located
        end else begin
          cnt_o = cnt_o + 1'b1;     // One more leading zero
        end
      end
    end
  end

  // Count wraps to 0 for an all-zero word so that case has its own flag
  assign empty_o = ~found;

endmodule

`default_nettype wire

/* source/cvt_ctrl_pkg.sv */
// Rounding and status definitions
`default_nettype none

package cvt_ctrl_pkg;

  // --------------------
  // Rounding modes
  // --------------------
  // Encoding follows the RISC-V frm field
  typedef enum logic [2:0] {
    RNE = 3'd0,  // Nearest with ties to even
    RTZ = 3'd1,  // Toward zero
    RDN = 3'd2,  // Toward minus infinity
    RUP = 3'd3,  // Toward plus infinity
    RMM = 3'd4   // Nearest with ties away from zero
  } roundmode_e;

  // --------------------
  // IEEE status flags
  // --------------------
  typedef struct packed {
    logic NV;  // Invalid operation
    logic DZ;  // Divide by zero
    logic OF;  // Overflow
    logic UF;  // Underflow
    logic NX;  // Inexact
  } status_t;

  // Only NX can fire in an int to float cast

endpackage

`default_nettype wire

/* source/cvt_fmt_pkg.sv */
// Integer and binary32 formats
`default_nettype none

package cvt_fmt_pkg;

  // --------------------
  // Integer operand
  // --------------------
  localparam int unsigned INT_WIDTH = 32;        // Operand width for signed or unsigned reads
  localparam int unsigned LZC_WIDTH = 5;         // Shift amount of 0 to 31

  // --------------------
  // binary32 result
  // --------------------
  localparam int unsigned FP_EXP_BITS = 8;       // Exponent field
  localparam int unsigned FP_MAN_BITS = 23;      // Stored fraction without the hidden bit
  localparam int unsigned FP_WIDTH    = 32;      // Sign + exponent + fraction
  localparam int unsigned FP_BIAS     = 127;

  // Internal exponent that holds bias plus 31 with room to spare
  localparam int unsigned EXP_WIDTH = 9;

  // --------------------
  // Word types
  // --------------------
  typedef logic [INT_WIDTH-1:0] int_word_t;      // One integer operand

  typedef logic [FP_WIDTH-1:0] fp_word_t;        // One packed float

endpackage

`default_nettype wire
